//--- hw/stat_defs.svh
// shared sizes and register offsets for the status-flag collector, included by RTL and testbench
`ifndef STAT_DEFS_SVH
`define STAT_DEFS_SVH

// number of sticky flag cells, one per event pulse from the datapath
`define STAT_NUM_FLAGS 8

// depth of every synchronizer chain in a flag cell, in both directions
// three stages leave margin for metastability at the datapath clock rates
`define STAT_SYNC_STAGES 3

// byte offsets of the four registers on the AXI4-Lite port
// the address bus is four bits wide, so offsets are given at that width

// raw sticky flags, read only
`define STAT_ADDR_STATUS 4'h0
// write one to clear a flag, reads back as zero
`define STAT_ADDR_CLEAR 4'h4
// interrupt enable per flag, read and write
`define STAT_ADDR_MASK 4'h8
// status ANDed with mask, read only
`define STAT_ADDR_PENDING 4'hC

`endif

//--- hw/stat_pkg.sv
// status-side types shared by the flag cells, the register block and the testbench
`include "stat_defs.svh"

package stat_pkg;

	// one bit per flag cell, used for event pulses, status, mask and clears alike
	typedef logic [`STAT_NUM_FLAGS-1:0] flag_vec_t;

	// decoded register selected by an AXI address
	// REG_NONE covers every address that maps to no register
	typedef enum logic [2:0] {
		REG_STATUS,
		REG_CLEAR,
		REG_MASK,
		REG_PENDING,
		REG_NONE
	} reg_sel_t;

endpackage

//--- hw/axil_pkg.sv
// AXI4-Lite bus types and response codes for the status register port
package axil_pkg;

	// register address, wide enough for the four word offsets
	typedef logic [3:0] axil_addr_t;

	// one data word on the read and write data channels
	typedef logic [31:0] axil_data_t;

	// response code on the B and R channels
	typedef logic [1:0] axil_resp_t;

	// normal completion
	localparam axil_resp_t RESP_OKAY = 2'b00;

	// slave error, answered for writes to read-only registers
	// and for any access to an unmapped address
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	// EXOKAY and DECERR are never produced by this slave

endpackage

//--- hw/sticky_flag.sv
// one flag cell that catches a flag_clk pulse and holds it in sys_clk until a toggled clear
`timescale 1ns/1ps
`include "stat_defs.svh"

module sticky_flag #(
	parameter int SYNC_STAGES = `STAT_SYNC_STAGES
) (
	input  logic flag_clk,
	input  logic rst,
	input  logic flag,
	input  logic sys_clk,
	input  logic sys_sclr,
	output logic sys_flag
);

	// launch register in the flag domain, the only signal that crosses forward
	logic                   flag_launch;
	// forward synchronizer, oldest stage at the top
	logic [SYNC_STAGES-1:0] flag_capture;
	// acknowledge level in sys_clk, it flips once per clear request
	logic                   sys_ack;
	// return synchronizer for the acknowledge level
	logic [SYNC_STAGES-1:0] ack_capture;
	// previous synchronized acknowledge, for the edge detector
	logic                   last_ack;
	// one flag_clk cycle high on every acknowledge edge
	logic                   flag_ack;

	// any change of the synchronized level is one clear request
	assign flag_ack = ack_capture[SYNC_STAGES-1] ^ last_ack;

	// the clear is applied first so that a pulse in the same cycle is not lost
	always_ff @(posedge flag_clk) begin
		if (rst) begin
			flag_launch <= 1'b0;
		end else begin
			if (flag_ack) begin
				flag_launch <= 1'b0;
			end
			if (flag) begin
				flag_launch <= 1'b1;
			end
		end
	end

	// bring the launch level into the register domain
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			flag_capture <= '0;
		end else begin
			flag_capture <= {flag_capture[SYNC_STAGES-2:0], flag_launch};
		end
	end

	assign sys_flag = flag_capture[SYNC_STAGES-1];

	// a level toggle survives the crossing where a one-cycle pulse would not
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			sys_ack <= 1'b0;
		end else if (sys_sclr) begin
			sys_ack <= ~sys_ack;
		end
	end

	// carry the acknowledge level back and keep its last value for the edge
	always_ff @(posedge flag_clk) begin
		if (rst) begin
			ack_capture <= '0;
			last_ack    <= 1'b0;
		end else begin
			ack_capture <= {ack_capture[SYNC_STAGES-2:0], sys_ack};
			last_ack    <= ack_capture[SYNC_STAGES-1];
		end
	end

	// a captured event may only be dropped by a clear that came back from sys_clk
	assert property (@(posedge flag_clk) disable iff (rst)
		flag_launch && !flag_ack |=> flag_launch)
		else $error("sticky_flag: launch register cleared without an acknowledge");

endmodule

//--- hw/axil_stat_regs.sv
// AXI4-Lite slave with STATUS, CLEAR, MASK and PENDING registers that steers the flag cells
`timescale 1ns/1ps
`include "stat_defs.svh"

module axil_stat_regs (
	input  logic                 sys_clk,
	input  logic                 rst,
	input  axil_pkg::axil_addr_t awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  axil_pkg::axil_data_t wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output axil_pkg::axil_resp_t bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  axil_pkg::axil_addr_t araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output axil_pkg::axil_data_t rdata,
	output axil_pkg::axil_resp_t rresp,
	output logic                 rvalid,
	input  logic                 rready,
	input  stat_pkg::flag_vec_t  status,
	output stat_pkg::flag_vec_t  sys_sclr,
	output logic                 irq
);

	import axil_pkg::*;
	import stat_pkg::*;

	// interrupt enable per flag
	flag_vec_t  mask_q;
	// flags that are both set and enabled
	flag_vec_t  pending;
	// decoded targets of the current write and read addresses
	reg_sel_t   wr_sel;
	reg_sel_t   rd_sel;
	// start raises the ready pulse, accept is the handshake cycle itself
	logic       wr_start;
	logic       wr_accept;
	logic       rd_start;
	logic       rd_accept;
	// byte strobes spread to one bit per data bit
	axil_data_t wr_lanes;
	// write data with unstrobed bytes forced to zero
	axil_data_t wr_bits;
	// read word and responses before they are registered
	axil_data_t rd_word;
	axil_resp_t rd_resp;
	axil_resp_t wr_resp;

	// map an address onto a register, anything off the word grid is unmapped
	function automatic reg_sel_t decode(input axil_addr_t addr);
		reg_sel_t sel;
		case (addr)
			`STAT_ADDR_STATUS:  sel = REG_STATUS;
			`STAT_ADDR_CLEAR:   sel = REG_CLEAR;
			`STAT_ADDR_MASK:    sel = REG_MASK;
			`STAT_ADDR_PENDING: sel = REG_PENDING;
			default:            sel = REG_NONE;
		endcase
		return sel;
	endfunction

	assign wr_sel = decode(awaddr);
	assign rd_sel = decode(araddr);

	// address and data are taken together, and never while a response waits
	assign wr_start  = awvalid && wvalid && !awready && !bvalid;
	// the master holds both valids until ready, so they are still high here
	assign wr_accept = awready && awvalid && wready && wvalid;
	assign rd_start  = arvalid && !arready && !rvalid;
	assign rd_accept = arready && arvalid;

	// both ready lines rise together, so one register serves them
	assign wready = awready;

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			wr_lanes[8*i +: 8] = {8{wstrb[i]}};
		end
	end

	assign wr_bits = wdata & wr_lanes;

	// only CLEAR and MASK accept writes, the status views are read only
	always_comb begin
		case (wr_sel)
			REG_CLEAR, REG_MASK: wr_resp = RESP_OKAY;
			default:             wr_resp = RESP_SLVERR;
		endcase
	end

	// a clear request lasts exactly the accept cycle, one cycle per written one
	assign sys_sclr = (wr_accept && wr_sel == REG_CLEAR) ?
		wr_bits[`STAT_NUM_FLAGS-1:0] : '0;

	// write address and response handshakes
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			awready <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			awready <= wr_start;
			if (wr_accept) begin
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_accept) begin
			bresp <= wr_resp;
		end
	end

	// strobed bytes of a MASK write replace the old value, other bytes keep it
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			mask_q <= '0;
		end else if (wr_accept && wr_sel == REG_MASK) begin
			mask_q <= (mask_q & ~wr_lanes[`STAT_NUM_FLAGS-1:0]) |
				wr_bits[`STAT_NUM_FLAGS-1:0];
		end
	end

	assign pending = status & mask_q;

	// follows a MASK write one cycle after it is accepted
	assign irq = |pending;

	// read mux, CLEAR reads as zero and unmapped space answers an error
	always_comb begin
		rd_word = '0;
		rd_resp = RESP_OKAY;
		case (rd_sel)
			REG_STATUS:  rd_word = axil_data_t'(status);
			REG_CLEAR:   rd_word = '0;
			REG_MASK:    rd_word = axil_data_t'(mask_q);
			REG_PENDING: rd_word = axil_data_t'(pending);
			default:     rd_resp = RESP_SLVERR;
		endcase
	end

	// read address and data handshakes
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= rd_start;
			if (rd_accept) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// the word is sampled once at accept and then frozen while rvalid waits
	always_ff @(posedge sys_clk) begin
		if (rd_accept) begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

	// a write response stays offered and unchanged until the master takes it
	assert property (@(posedge sys_clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("axil_stat_regs: write response dropped or changed before bready");

	// the same holds for read data and its response
	assert property (@(posedge sys_clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("axil_stat_regs: read data dropped or changed before rready");

endmodule

//--- hw/stat_flag_top.sv
// top level of the status-flag collector, flag cells beside their AXI4-Lite register block
`timescale 1ns/1ps
`include "stat_defs.svh"

module stat_flag_top (
	input  logic                 flag_clk,
	input  logic                 sys_clk,
	input  logic                 rst,
	input  stat_pkg::flag_vec_t  flag,
	input  axil_pkg::axil_addr_t awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  axil_pkg::axil_data_t wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output axil_pkg::axil_resp_t bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  axil_pkg::axil_addr_t araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output axil_pkg::axil_data_t rdata,
	output axil_pkg::axil_resp_t rresp,
	output logic                 rvalid,
	input  logic                 rready,
	output logic                 irq
);

	import stat_pkg::*;

	// clear pulses from the register block, one per cell
	flag_vec_t sys_sclr;
	// synchronized sticky flags gathered back into one vector
	flag_vec_t status;

	// each cell crosses one event bit and its clear on its own
	for (genvar i = 0; i < `STAT_NUM_FLAGS; i++) begin : g_flag
		sticky_flag #(
			.SYNC_STAGES(`STAT_SYNC_STAGES)
		) u_flag (
			.flag_clk (flag_clk),
			.rst      (rst),
			.flag     (flag[i]),
			.sys_clk  (sys_clk),
			.sys_sclr (sys_sclr[i]),
			.sys_flag (status[i])
		);
	end

	// software view of the flags, entirely in sys_clk
	axil_stat_regs u_regs (
		.sys_clk  (sys_clk),
		.rst      (rst),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.status   (status),
		.sys_sclr (sys_sclr),
		.irq      (irq)
	);

endmodule

//--- dv/stat_flag_tb.sv
// table-driven testbench for stat_flag_top, run it as the top module with the file list
`timescale 1ns/1ps
`include "stat_defs.svh"

module stat_flag_tb;

	import stat_pkg::*;
	import axil_pkg::*;

	// kinds of table rows, a pulse row with zero data takes its vector from the LFSR
	typedef enum logic [1:0] {OP_PULSE, OP_WRITE, OP_READ, OP_SETTLE} op_t;

	typedef struct {
		op_t        op;
		axil_addr_t addr;
		axil_data_t data;
		axil_data_t exp_data;
		axil_resp_t exp_resp;
	} row_t;

	logic       flag_clk = 1'b0;
	logic       sys_clk = 1'b0;
	logic       rst;
	flag_vec_t  flag;
	axil_addr_t awaddr;
	logic       awvalid;
	logic       awready;
	axil_data_t wdata;
	logic [3:0] wstrb;
	logic       wvalid;
	logic       wready;
	axil_resp_t bresp;
	logic       bvalid;
	logic       bready;
	axil_addr_t araddr;
	logic       arvalid;
	logic       arready;
	axil_data_t rdata;
	axil_resp_t rresp;
	logic       rvalid;
	logic       rready;
	logic       irq;

	row_t        rows[$];
	// reference state, clears wait in clear_queued until the next settle row has run
	flag_vec_t   model_status = '0;
	flag_vec_t   model_mask = '0;
	flag_vec_t   clear_queued = '0;
	logic [15:0] lfsr_state = 16'd13;
	int          check_count = 0;
	int          error_count = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	always #20 flag_clk = ~flag_clk;
	always #12 sys_clk = ~sys_clk;

	stat_flag_top UUT (
		.flag_clk (flag_clk), .sys_clk (sys_clk), .rst (rst), .flag (flag),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
		.irq (irq)
	);

	// the whole run is bounded by the table length, every row gets 40 flag_clk cycles
	always @(posedge flag_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run did not finish within %0d flag_clk cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// taps 16, 14, 13 and 11 give a maximal length sequence
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one LFSR step for every flag bit that is drawn
	function automatic flag_vec_t draw_vector();
		flag_vec_t v;
		for (int i = 0; i < `STAT_NUM_FLAGS; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
		return v;
	endfunction

	function automatic void add_row(op_t op, axil_addr_t addr, axil_data_t data,
			axil_data_t exp_data, axil_resp_t exp_resp);
		row_t r;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.exp_data = exp_data;
		r.exp_resp = exp_resp;
		rows.push_back(r);
	endfunction

	// a one-cycle pulse in the datapath domain
	task automatic pulse_flags(input flag_vec_t vec);
		@(negedge flag_clk);
		flag = vec;
		@(negedge flag_clk);
		flag = '0;
	endtask

	// address and data go out together, bready is held low one cycle to test the hold
	task automatic bus_write(input axil_addr_t addr, input axil_data_t data,
			output axil_resp_t resp);
		@(negedge sys_clk);
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge sys_clk);
		while (!awready && !wready) @(negedge sys_clk);
		// both ready lines belong to one handshake and must rise in the same cycle
		check_count++;
		if (awready !== wready) begin
			$display("[ERROR] %0t: awready %b and wready %b did not rise together",
				$time, awready, wready);
			error_count++;
		end
		// the handshake completes on the rising edge that follows
		@(negedge sys_clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid) @(negedge sys_clk);
		@(negedge sys_clk);
		resp = bresp;
		bready = 1'b1;
		@(negedge sys_clk);
		bready = 1'b0;
	endtask

	// rready is held low one cycle so that the read data has to hold
	task automatic bus_read(input axil_addr_t addr, output axil_data_t data,
			output axil_resp_t resp);
		@(negedge sys_clk);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge sys_clk);
		while (!arready) @(negedge sys_clk);
		@(negedge sys_clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge sys_clk);
		@(negedge sys_clk);
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge sys_clk);
		rready = 1'b0;
	endtask

	task automatic run_row(input int idx);
		row_t       row;
		flag_vec_t  vec;
		axil_data_t got_data;
		axil_resp_t got_resp;
		axil_data_t want;
		logic       want_irq;
		row = rows[idx];
		case (row.op)
			OP_PULSE: begin
				if (row.data == '0) vec = draw_vector();
				else vec = row.data[`STAT_NUM_FLAGS-1:0];
				pulse_flags(vec);
				model_status = model_status | vec;
				$display("row %0d: pulse 0x%h", idx, vec);
			end
			OP_WRITE: begin
				bus_write(row.addr, row.data, got_resp);
				check_count++;
				if (got_resp !== row.exp_resp) begin
					$display("[ERROR] %0t: row %0d write to 0x%h gave resp %0d, expected %0d",
						$time, idx, row.addr, got_resp, row.exp_resp);
					error_count++;
				end
				// only MASK and CLEAR take writes, STATUS and PENDING stay as they are
				if (row.addr == `STAT_ADDR_MASK) model_mask = row.data[`STAT_NUM_FLAGS-1:0];
				if (row.addr == `STAT_ADDR_CLEAR)
					clear_queued = clear_queued | row.data[`STAT_NUM_FLAGS-1:0];
				$display("row %0d: write 0x%h to 0x%h, resp %0d", idx, row.data, row.addr,
					got_resp);
			end
			OP_READ: begin
				bus_read(row.addr, got_data, got_resp);
				// the two flag views come from the model, the table covers the rest
				if (row.addr == `STAT_ADDR_STATUS) want = axil_data_t'(model_status);
				else if (row.addr == `STAT_ADDR_PENDING)
					want = axil_data_t'(model_status & model_mask);
				else want = row.exp_data;
				check_count += 2;
				if (got_data !== want) begin
					$display("[ERROR] %0t: row %0d read 0x%h returned 0x%h, expected 0x%h",
						$time, idx, row.addr, got_data, want);
					error_count++;
				end
				if (got_resp !== row.exp_resp) begin
					$display("[ERROR] %0t: row %0d read 0x%h gave resp %0d, expected %0d",
						$time, idx, row.addr, got_resp, row.exp_resp);
					error_count++;
				end
				$display("row %0d: read 0x%h = 0x%h, resp %0d", idx, row.addr, got_data,
					got_resp);
			end
			default: begin
				repeat (20) @(negedge sys_clk);
				// every round trip has finished by now, so queued clears take effect
				model_status = model_status & ~clear_queued;
				clear_queued = '0;
				want_irq = |(model_status & model_mask);
				check_count++;
				if (irq !== want_irq) begin
					$display("[ERROR] %0t: row %0d irq is %b, expected %b",
						$time, idx, irq, want_irq);
					error_count++;
				end
				$display("row %0d: settle, irq %b", idx, irq);
			end
		endcase
	endtask

	task automatic build_table();
		// reset values
		add_row(OP_READ, `STAT_ADDR_STATUS, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_MASK, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_PENDING, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
		// sticky capture survives further settles
		add_row(OP_PULSE, 4'h0, 32'h05, 32'h0, RESP_OKAY);
		add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_STATUS, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_STATUS, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_PULSE, 4'h0, 32'h80, 32'h0, RESP_OKAY);
		add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_STATUS, 32'h0, 32'h0, RESP_OKAY);
		// mask readback, pending view and interrupt
		add_row(OP_WRITE, `STAT_ADDR_MASK, 32'h0F, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_MASK, 32'h0, 32'h0F, RESP_OKAY);
		add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_PENDING, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_WRITE, `STAT_ADDR_MASK, 32'hF0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_MASK, 32'h0, 32'hF0, RESP_OKAY);
		add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_PENDING, 32'h0, 32'h0, RESP_OKAY);
		// write one to clear, each clear gets its own round trip
		add_row(OP_WRITE, `STAT_ADDR_CLEAR, 32'h04, 32'h0, RESP_OKAY);
		add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_STATUS, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_CLEAR, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_WRITE, `STAT_ADDR_CLEAR, 32'h80, 32'h0, RESP_OKAY);
		add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_PENDING, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_STATUS, 32'h0, 32'h0, RESP_OKAY);
		// error responses, STATUS must not change
		add_row(OP_WRITE, `STAT_ADDR_STATUS, 32'hFF, 32'h0, RESP_SLVERR);
		add_row(OP_WRITE, `STAT_ADDR_PENDING, 32'hFF, 32'h0, RESP_SLVERR);
		add_row(OP_READ, 4'h2, 32'h0, 32'h0, RESP_SLVERR);
		add_row(OP_READ, 4'hE, 32'h0, 32'h0, RESP_SLVERR);
		add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
		add_row(OP_READ, `STAT_ADDR_STATUS, 32'h0, 32'h0, RESP_OKAY);
		// random accumulation with clears in between
		add_row(OP_WRITE, `STAT_ADDR_MASK, 32'hFF, 32'h0, RESP_OKAY);
		for (int k = 0; k < 3; k++) begin
			add_row(OP_PULSE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
			add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
			add_row(OP_READ, `STAT_ADDR_STATUS, 32'h0, 32'h0, RESP_OKAY);
			add_row(OP_READ, `STAT_ADDR_PENDING, 32'h0, 32'h0, RESP_OKAY);
			add_row(OP_WRITE, `STAT_ADDR_CLEAR, (k == 1) ? 32'hC3 : 32'h3C, 32'h0, RESP_OKAY);
			add_row(OP_SETTLE, 4'h0, 32'h0, 32'h0, RESP_OKAY);
			add_row(OP_READ, `STAT_ADDR_STATUS, 32'h0, 32'h0, RESP_OKAY);
		end
	endtask

	initial begin
		rst = 1'b1;
		flag = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		build_table();
		cycle_limit = rows.size() * 40;
		repeat (4) @(negedge flag_clk);
		rst = 1'b0;
		for (int r = 0; r < rows.size(); r++) begin
			run_row(r);
		end
		$display("rows %0d, checks %0d, errors %0d", rows.size(), check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- stat_flag_top.f
+incdir+hw
hw/stat_pkg.sv
hw/axil_pkg.sv
hw/sticky_flag.sv
hw/axil_stat_regs.sv
hw/stat_flag_top.sv
dv/stat_flag_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module stat_flag_tb \
	-f stat_flag_top.f -o stat_flag_sim &&
sim_out="$(./obj_dir/stat_flag_sim)" ;
echo "$sim_out" ;
echo "$sim_out" | grep -qx "TEST PASSED" &&
echo "simulation result: pass" ||
{ echo "simulation result: fail"; exit 1; }
